//--- logic/arbiterPkg.sv
package arbiterPkg;

  // ============================================================
  // Ports and grant state
  // ============================================================
  localparam int numPorts = 5;

  typedef enum logic [2:0] {
    L = 3'd0,
    N = 3'd1,
    E = 3'd2,
    W = 3'd3,
    S = 3'd4
  } portT;

  typedef logic [numPorts:0] grantStateT; // Bit 0 idle, bits 1..5 ports L..S

  localparam grantStateT stateIdle = 6'b000001;

  // ============================================================
  // Rotation helpers
  // ============================================================
  function automatic grantStateT portToState(portT p);
    return grantStateT'(6'b000010 << p);
  endfunction

  function automatic portT stateToPort(grantStateT s);
    portT p;
    p = L;
    for (int k = 0; k < numPorts; k++)
    begin
      if (s[k+1])
        p = portT'(k);
    end
    return p;
  endfunction

  function automatic portT nextPort(portT p);
    return (p == S) ? L : portT'(p + 3'd1);
  endfunction

  // First requester among span ports, scanning from first
  function automatic grantStateT pickNext(portT first, logic [numPorts-1:0] req, int span);
    portT cand;
    grantStateT pick;
    logic found;
    cand  = first;
    pick  = stateIdle;
    found = 1'b0;
    for (int k = 0; k < numPorts; k++)
    begin
      if (k < span && !found && req[cand])
      begin
        pick  = portToState(cand);
        found = 1'b1;
      end
      cand = nextPort(cand);
    end
    return pick;
  endfunction

endpackage

//--- logic/nocFlitPkg.sv
package nocFlitPkg;
  import arbiterPkg::*;

  // ============================================================
  // Flit format
  // ============================================================
  localparam int lengthWidth = 12;

  typedef logic [2:0] flitIdT;

  localparam flitIdT flitHeader = 3'd1;
  localparam flitIdT flitBody   = 3'd2;
  localparam flitIdT flitTail   = 3'd3;

  typedef struct packed {
    flitIdT      flitId;
    logic [31:0] data; // Header: length in low bits
  } flitT;

  // Flit after the switch, tagged with where it came from
  typedef struct packed {
    portT srcPort;
    flitT flit;
  } taggedFlitT;

endpackage

//--- logic/flitFifo.sv
`timescale 1ns/1ps

module flitFifo #(
  parameter type payloadT = logic [7:0],
  parameter int  depth    = 4
) (
  input  logic    clk,
  input  logic    rst,
  input  payloadT wrData,
  input  logic    wrValid,
  output logic    wrReady,
  output payloadT rdData,
  output logic    rdValid,
  input  logic    rdReady
);

  localparam int ptrWidth = (depth > 1) ? $clog2(depth) : 1;
  localparam int cntWidth = $clog2(depth + 1);

  payloadT mem [depth];

  logic [ptrWidth-1:0] wrPtr;
  logic [ptrWidth-1:0] rdPtr;
  logic [cntWidth-1:0] used;
  logic                full;
  logic                push;
  logic                popNow;

  assign full    = (used == cntWidth'(depth));
  assign rdValid = (used != '0);
  assign rdData  = mem[rdPtr];
  assign wrReady = !full || rdReady; // Full but draining this cycle

  assign push   = wrValid && wrReady;
  assign popNow = rdValid && rdReady;

  // ============================================================
  // Pointers and occupancy
  // ============================================================
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      used  <= '0;
    end
    else
    begin
      if (push)
        wrPtr <= (wrPtr == ptrWidth'(depth - 1)) ? '0 : wrPtr + 1'b1;
      if (popNow)
        rdPtr <= (rdPtr == ptrWidth'(depth - 1)) ? '0 : rdPtr + 1'b1;
      case ({push, popNow})
        2'b10:   used <= used + 1'b1;
        2'b01:   used <= used - 1'b1;
        default: used <= used;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk)
  begin
    if (push)
      mem[wrPtr] <= wrData;
  end

endmodule

//--- logic/holdTimer.sv
`timescale 1ns/1ps

module holdTimer
  import nocFlitPkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic [lengthWidth-1:0] loadLength,
  input  logic                   load,
  input  logic                   count,
  input  logic                   held,
  output logic                   timesUp
);

  logic [lengthWidth-1:0] limit;
  logic [lengthWidth-1:0] runCount;
  logic [lengthWidth-1:0] nextLimit;
  logic [lengthWidth-1:0] nextRun;

  always_comb
  begin
    nextLimit = limit;
    if (load)
      nextLimit = (loadLength == '0) ? lengthWidth'(1) : loadLength; // Zero length holds one
    nextRun = held ? runCount + lengthWidth'(count) : '0;
  end

  // Looks at the count after this cycle's move
  assign timesUp = (nextRun >= nextLimit);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit    <= lengthWidth'(1);
      runCount <= '0;
    end
    else
    begin
      limit    <= nextLimit;
      runCount <= nextRun;
    end
  end

endmodule

//--- logic/portArbiter.sv
`timescale 1ns/1ps

module portArbiter
  import arbiterPkg::*;
  import nocFlitPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  flitT                headFlit [numPorts],
  input  logic [numPorts-1:0] headValid,
  output logic [numPorts-1:0] pop,
  output taggedFlitT          swFlit,
  output logic                swValid,
  input  logic                swReady
);

  grantStateT          state;
  grantStateT          nextState;
  portT                grantedPort;
  logic                granted;
  logic                move;
  logic [numPorts-1:0] timesUp;
  logic [numPorts-1:0] isHeader;

  assign granted     = !state[0];
  assign grantedPort = stateToPort(state);

  // ============================================================
  // Hold timers, one per input port
  // ============================================================
  for (genvar p = 0; p < numPorts; p++)
  begin : g_timer
    assign isHeader[p] = (headFlit[p].flitId == flitHeader);

    holdTimer i_timer (
      .clk        (clk),
      .rst        (rst),
      .loadLength (headFlit[p].data[lengthWidth-1:0]),
      .load       (pop[p] && isHeader[p]),
      .count      (pop[p]),
      .held       (state[p+1]),
      .timesUp    (timesUp[p])
    );
  end

  // ============================================================
  // Grant state machine
  // ============================================================
  always_comb
  begin
    if (!granted)
      nextState = pickNext(L, headValid, numPorts); // Idle order L N E W S
    else if (headValid[grantedPort] && !timesUp[grantedPort])
      nextState = state;
    else
      nextState = pickNext(nextPort(grantedPort), headValid, numPorts - 1);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= stateIdle;
    else
      state <= nextState;
  end

  // ============================================================
  // Switch
  // ============================================================
  assign swValid = granted && headValid[grantedPort];
  assign move    = swValid && swReady;

  always_comb
  begin
    swFlit.srcPort = grantedPort;
    swFlit.flit    = headFlit[grantedPort];
  end

  always_comb
  begin
    for (int k = 0; k < numPorts; k++)
    begin
      pop[k] = move && (grantedPort == portT'(k)); // Only the holder drains
    end
  end

endmodule

//--- logic/routerOutputPort.sv
`timescale 1ns/1ps

module routerOutputPort
  import arbiterPkg::*;
  import nocFlitPkg::*;
#(
  parameter int inDepth  = 4,
  parameter int outDepth = 2
) (
  input  logic                clk,
  input  logic                rst,
  input  flitT                inFlit [numPorts],
  input  logic [numPorts-1:0] inValid,
  output logic [numPorts-1:0] inReady,
  output taggedFlitT          outFlit,
  output logic                outValid,
  input  logic                outReady
);

  flitT                headFlit [numPorts];
  logic [numPorts-1:0] headValid;
  logic [numPorts-1:0] pop;
  taggedFlitT          swFlit;
  logic                swValid;
  logic                swReady;

  // ============================================================
  // Input buffers
  // ============================================================
  for (genvar p = 0; p < numPorts; p++)
  begin : g_in
    flitFifo #(
      .payloadT (flitT),
      .depth    (inDepth)
    ) i_inFifo (
      .clk     (clk),
      .rst     (rst),
      .wrData  (inFlit[p]),
      .wrValid (inValid[p]),
      .wrReady (inReady[p]),
      .rdData  (headFlit[p]),
      .rdValid (headValid[p]),
      .rdReady (pop[p])
    );
  end

  portArbiter i_arbiter (
    .clk       (clk),
    .rst       (rst),
    .headFlit  (headFlit),
    .headValid (headValid),
    .pop       (pop),
    .swFlit    (swFlit),
    .swValid   (swValid),
    .swReady   (swReady)
  );

  // Output buffer
  flitFifo #(
    .payloadT (taggedFlitT),
    .depth    (outDepth)
  ) i_outFifo (
    .clk     (clk),
    .rst     (rst),
    .wrData  (swFlit),
    .wrValid (swValid),
    .wrReady (swReady),
    .rdData  (outFlit),
    .rdValid (outValid),
    .rdReady (outReady)
  );

endmodule

//--- verification/routerOutputPort_assertions.sv
`timescale 1ns/1ps

module routerOutputPortAssertions
  import arbiterPkg::*;
(
  input logic                clk,
  input logic                rst,
  input grantStateT          state,
  input logic [numPorts-1:0] pop,
  input logic                swReady
);

  // Idle counts as one of the states
  stateOneHot: assert property (@(posedge clk) disable iff (rst) $onehot(state))
    else $error("grant state %b is not one-hot", state);

  popOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(pop))
    else $error("more than one pop high: %b", pop);

  popGranted: assert property (@(posedge clk) disable iff (rst)
    (pop != '0) |-> (swReady && ((pop & ~state[numPorts:1]) == '0)))
    else $error("pop %b outside granted state %b or without swReady", pop, state);

endmodule

bind portArbiter routerOutputPortAssertions i_assertions (
  .clk     (clk),
  .rst     (rst),
  .state   (state),
  .pop     (pop),
  .swReady (swReady)
);

//--- verification/routerOutputPortTb.sv
`timescale 1ns/1ps

module routerOutputPortTb
  import arbiterPkg::*;
  import nocFlitPkg::*;
();

  localparam int inDepth       = 4;
  localparam int outDepth      = 2;
  localparam int trafficCycles = 2000;
  localparam int drainLimit    = 2000;
  localparam int fillLimit     = 300;
  localparam int holdCycles    = 20;

  localparam logic [1:0] readyRandom = 2'd0;
  localparam logic [1:0] readyLow    = 2'd1;
  localparam logic [1:0] readyHigh   = 2'd2;

  logic                clk;
  logic                rst;
  flitT                inFlit [numPorts];
  logic [numPorts-1:0] inValid;
  logic [numPorts-1:0] inReady;
  taggedFlitT          outFlit;
  logic                outValid;
  logic                outReady;

  logic       sendEnable; // Stimulus controls set on the rising edge
  logic       fillMode;
  logic [1:0] readyMode;

  integer     seed = 32'he55d;
  int         bodyLeft [numPorts];
  int         holdLimit [numPorts];
  flitT       switchModel [numPorts][$];
  flitT       outModel [numPorts][$];
  int         acceptedCount = 0;
  int         outCount = 0;
  int         checkCount = 0;
  int         errorCount = 0;
  int         runLength = 0;
  grantStateT lastState = stateIdle;
  logic       stalled = 1'b0;
  taggedFlitT stalledFlit;

  routerOutputPort #(
    .inDepth  (inDepth),
    .outDepth (outDepth)
  ) i_dut (
    .clk      (clk),
    .rst      (rst),
    .inFlit   (inFlit),
    .inValid  (inValid),
    .inReady  (inReady),
    .outFlit  (outFlit),
    .outValid (outValid),
    .outReady (outReady)
  );

  always #20 clk = ~clk;

  // ============================================================
  // Checks and stimulus helpers
  // ============================================================
  task automatic compareValue(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
    checkCount++;
    if (actual !== expected)
    begin
      errorCount++;
      $display("mismatch %s: got %h, expected %h", name, actual, expected);
    end
  endtask

  task automatic reportFailure(input string what);
    errorCount++;
    $display("error: %s", what);
  endtask

  // Header with length 0..6, then 0..4 body flits
  function automatic flitT makeFlit(int port);
    flitT        f;
    logic [31:0] r;
    r = $random(seed);
    if (bodyLeft[port] == 0)
    begin
      f.flitId       = flitHeader;
      f.data         = r;
      f.data[lengthWidth-1:0] = lengthWidth'($unsigned($random(seed)) % 7);
      bodyLeft[port] = $unsigned($random(seed)) % 5;
    end
    else
    begin
      f.flitId = flitBody;
      f.data   = r;
      bodyLeft[port]--;
    end
    return f;
  endfunction

  function automatic logic randomChance();
    return ($unsigned($random(seed)) % 4) != 0; // Three in four
  endfunction

  function automatic logic isDrained();
    logic empty;
    empty = (inValid == '0) && !outValid;
    for (int p = 0; p < numPorts; p++)
    begin
      empty = empty && (outModel[p].size() == 0);
    end
    return empty;
  endfunction

  task automatic waitDrained(input string what);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!isDrained() && cycles < drainLimit)
    begin
      @(negedge clk);
      cycles++;
    end
    if (!isDrained())
      reportFailure($sformatf("timed out waiting for the %s traffic to drain", what));
  endtask

  task automatic checkSwitchMove(input taggedFlitT moved);
    int   port;
    flitT expected;
    port = int'(moved.srcPort);
    if (port >= numPorts || switchModel[port].size() == 0)
      reportFailure($sformatf("switch moved a flit from port %0d that was never accepted", port));
    else
    begin
      expected = switchModel[port].pop_front();
      compareValue("swFlit", 64'(moved.flit), 64'(expected));
      if (runLength > 0 && runLength >= holdLimit[port])
        reportFailure($sformatf("port %0d kept the grant past its limit of %0d flits",
                                port, holdLimit[port]));
      runLength++;
      if (expected.flitId == flitHeader) // Zero length holds for one flit
        holdLimit[port] = (expected.data[lengthWidth-1:0] == '0) ? 1 :
                          int'(expected.data[lengthWidth-1:0]);
    end
  endtask

  task automatic checkOutputFlit(input taggedFlitT got);
    int port;
    port = int'(got.srcPort);
    outCount++;
    if (port >= numPorts || outModel[port].size() == 0)
      reportFailure($sformatf("output flit from port %0d was never accepted", port));
    else
      compareValue("outFlit", 64'(got.flit), 64'(outModel[port].pop_front()));
  endtask

  // ============================================================
  // Driver and monitor
  // ============================================================
  always @(posedge clk)
  begin
    if (rst)
      inValid <= '0;
    else
    begin
      for (int p = 0; p < numPorts; p++)
      begin
        if (inValid[p] && inReady[p])
        begin
          inFlit[p]  <= makeFlit(p);
          inValid[p] <= sendEnable && (fillMode || randomChance());
        end
        else if (!inValid[p])
          inValid[p] <= sendEnable && (fillMode || randomChance());
      end
      case (readyMode)
        readyLow:  outReady <= 1'b0;
        readyHigh: outReady <= 1'b1;
        default:   outReady <= 1'($random(seed));
      endcase
    end
  end

  always @(posedge clk)
  begin
    if (!rst)
    begin
      for (int p = 0; p < numPorts; p++)
      begin
        if (inValid[p] && inReady[p])
        begin
          switchModel[p].push_back(inFlit[p]);
          outModel[p].push_back(inFlit[p]);
          acceptedCount++;
        end
      end
      if (i_dut.i_arbiter.state != lastState)
        runLength = 0; // New grant tenure
      lastState = i_dut.i_arbiter.state;
      if (i_dut.i_arbiter.pop != '0)
        checkSwitchMove(i_dut.i_arbiter.swFlit);
      if (stalled)
      begin
        compareValue("outValid", 64'(outValid), 64'(1'b1));
        compareValue("outFlit", 64'(outFlit), 64'(stalledFlit));
      end
      if (outValid && outReady)
        checkOutputFlit(outFlit);
      stalled     = outValid && !outReady;
      stalledFlit = outFlit;
    end
  end

  // ============================================================
  // Test sequence
  // ============================================================
  initial
  begin
    int startErrors;
    int startCount;
    int cycles;
    clk        = 1'b0;
    rst        <= 1'b1;
    inValid    <= '0;
    outReady   <= 1'b0;
    sendEnable <= 1'b0;
    fillMode   <= 1'b0;
    readyMode  <= readyHigh;
    for (int p = 0; p < numPorts; p++)
    begin
      bodyLeft[p]  = 0;
      holdLimit[p] = 1; // Before any header
      inFlit[p]    <= makeFlit(p);
    end
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    @(negedge clk);
    compareValue("outValid", 64'(outValid), 64'(1'b0));
    compareValue("inReady", 64'(inReady), 64'({numPorts{1'b1}}));
    $display("test reset: done, %0d errors", errorCount);

    startErrors = errorCount;
    @(posedge clk);
    sendEnable <= 1'b1;
    readyMode  <= readyRandom;
    repeat (trafficCycles) @(posedge clk);
    sendEnable <= 1'b0;
    readyMode  <= readyHigh;
    waitDrained("random");
    compareValue("flitsOut", 64'(outCount), 64'(acceptedCount));
    $display("test random traffic: done, %0d flits, %0d errors",
             outCount, errorCount - startErrors);

    // Output stalled while every input pushes
    startErrors = errorCount;
    @(posedge clk);
    readyMode  <= readyLow;
    fillMode   <= 1'b1;
    sendEnable <= 1'b1;
    startCount = acceptedCount;
    cycles     = 0;
    @(negedge clk);
    while (inReady != '0 && cycles < fillLimit)
    begin
      @(negedge clk);
      cycles++;
    end
    if (inReady != '0)
      reportFailure("timed out waiting for the input buffers to fill");
    repeat (holdCycles)
    begin
      @(negedge clk);
      compareValue("inReady", 64'(inReady), 64'(0));
    end
    compareValue("flitsAccepted", 64'(acceptedCount - startCount),
                 64'(numPorts * inDepth + outDepth));
    @(posedge clk);
    readyMode  <= readyHigh;
    sendEnable <= 1'b0;
    fillMode   <= 1'b0;
    waitDrained("fill");
    compareValue("flitsOut", 64'(outCount), 64'(acceptedCount));
    $display("test buffer fill: done, %0d errors", errorCount - startErrors);

    $display("summary: %0d checks, %0d errors, %0d flits accepted, %0d flits delivered",
             checkCount, errorCount, acceptedCount, outCount);
    if (errorCount == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- routerOutputPort.f
logic/arbiterPkg.sv
logic/nocFlitPkg.sv
logic/flitFifo.sv
logic/holdTimer.sv
logic/portArbiter.sv
logic/routerOutputPort.sv
verification/routerOutputPort_assertions.sv
verification/routerOutputPortTb.sv

//--- Makefile
VERILATOR       ?= verilator
TOP             ?= routerOutputPortTb
FILELIST        ?= routerOutputPort.f
OBJ_DIR         ?= obj_dir
LOG             ?= sim.log
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal
FAIL_MSG        ?= TESTBENCH FAILED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILELIST) \
	  --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
